//--- verilog/tinker_pkg.sv
// Tinker core shared definitions
`default_nettype none

package tinker_pkg;

    // ----------------------------------------------------------
    // Widths
    // ----------------------------------------------------------
    localparam int XLEN       = 64;   // Data path
    localparam int ILEN       = 32;   // Instruction word
    localparam int ALEN       = 32;   // Byte address and PC
    localparam int REG_ADDR_W = 5;    // 32 registers
    localparam int LIT_W      = 12;   // Literal field

    // Kept opcodes only, encodings as in the ISA
    typedef enum logic [4:0] {
        OP_AND    = 5'h00,
        OP_OR     = 5'h01,
        OP_XOR    = 5'h02,
        OP_NOT    = 5'h03,
        OP_SHFTR  = 5'h04,
        OP_SHFTRI = 5'h05,
        OP_SHFTL  = 5'h06,
        OP_SHFTLI = 5'h07,
        OP_BRR_L  = 5'h0a,   // PC relative by literal
        OP_BRNZ   = 5'h0b,
        OP_HALT   = 5'h0f,
        OP_LD     = 5'h10,
        OP_MOV_RR = 5'h11,
        OP_MOV_RL = 5'h12,   // Low 12 bits of rd only
        OP_ST     = 5'h13,
        OP_ADD    = 5'h18,
        OP_ADDI   = 5'h19,
        OP_SUB    = 5'h1a,
        OP_SUBI   = 5'h1b,
        OP_MUL    = 5'h1c
    } opcode_t;

    // One state per cycle of an instruction
    typedef enum logic [2:0] {
        IDLE, FETCH, DECODE, EXECUTE, MEMORY, WRITEBACK, HALT
    } state_t;

    // Field layout, MSB first
    typedef struct packed {
        opcode_t                 opcode;  // [31:27]
        logic [REG_ADDR_W-1:0]   rd;      // [26:22]
        logic [REG_ADDR_W-1:0]   rs;      // [21:17]
        logic [REG_ADDR_W-1:0]   rt;      // [16:12]
        logic [LIT_W-1:0]        lit;     // [11:0]
    } insn_t;

endpackage

`default_nettype wire

//--- verilog/tinker_mem_if.sv
// Data memory port
`timescale 1ns/1ps
`default_nettype none

interface tinker_mem_if import tinker_pkg::*; ();

    logic [ALEN-1:0] load_addr;   // Combinational read address
    logic [XLEN-1:0] load_data;   // Valid same cycle
    logic            store_we;    // One-cycle strobe
    logic [ALEN-1:0] store_addr;
    logic [XLEN-1:0] store_data;  // 8 bytes, big-endian

    // Control side
    modport ctrl (output load_addr, store_we, store_addr, store_data,
                  input  load_data);

    // Memory side
    modport mem  (input  load_addr, store_we, store_addr, store_data,
                  output load_data);

endinterface

`default_nettype wire

//--- verilog/tinker_mem.sv
// Unified byte memory
`timescale 1ns/1ps
`default_nettype none

module tinker_mem import tinker_pkg::*; #(
    parameter int MEM_BYTES = 16384
) (
    input  wire logic            clk,
    tinker_mem_if.mem            mem,
    input  wire logic [ALEN-1:0] fetch_addr,
    output logic      [ILEN-1:0] fetch_insn,
    input  wire logic            prog_we,     // Loader, run low only
    input  wire logic [ALEN-1:0] prog_addr,
    input  wire logic [ILEN-1:0] prog_data
);

    logic [7:0] bytes [MEM_BYTES];   // No reset, contents come from loader

    // ----------------------------------------------------------
    // Reads, big-endian, no latency
    // ----------------------------------------------------------
    always_comb begin
        for (int i = 0; i < ILEN / 8; i++) begin
            fetch_insn[ILEN-1-8*i -: 8] = bytes[fetch_addr + ALEN'(i)];  // MSB first
        end
    end

    always_comb begin
        for (int i = 0; i < XLEN / 8; i++) begin
            mem.load_data[XLEN-1-8*i -: 8] = bytes[mem.load_addr + ALEN'(i)];
        end
    end

    // ----------------------------------------------------------
    // Writes at the edge
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (mem.store_we) begin
            for (int i = 0; i < XLEN / 8; i++) begin
                bytes[mem.store_addr + ALEN'(i)] <= mem.store_data[XLEN-1-8*i -: 8];
            end
        end
        // Program words land one instruction at a time
        if (prog_we) begin
            for (int i = 0; i < ILEN / 8; i++) begin
                bytes[prog_addr + ALEN'(i)] <= prog_data[ILEN-1-8*i -: 8];
            end
        end
    end

    // Store address comes from control, last byte must still fit
    a_store_in_range: assert property (
        @(posedge clk) mem.store_we |-> (longint'(mem.store_addr) + 8 <= longint'(MEM_BYTES))
    ) else $error("store past end of memory at %h", mem.store_addr);

    // Same for the loader
    a_prog_in_range: assert property (
        @(posedge clk) prog_we |-> (longint'(prog_addr) + 4 <= longint'(MEM_BYTES))
    ) else $error("program write past end of memory at %h", prog_addr);

endmodule

`default_nettype wire

//--- verilog/tinker_regfile.sv
// Integer register file
`timescale 1ns/1ps
`default_nettype none

module tinker_regfile import tinker_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  we,
    input  wire logic [REG_ADDR_W-1:0] waddr,
    input  wire logic [XLEN-1:0]       wdata,
    input  wire logic [REG_ADDR_W-1:0] raddr_a,
    input  wire logic [REG_ADDR_W-1:0] raddr_b,
    output logic      [XLEN-1:0]       rdata_a,
    output logic      [XLEN-1:0]       rdata_b
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    // Whole file clears on reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;   // Seen by reads next cycle
        end
    end

    // Two combinational read ports
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

endmodule

`default_nettype wire

//--- verilog/tinker_alu.sv
// Integer ALU
`timescale 1ns/1ps
`default_nettype none

module tinker_alu import tinker_pkg::*; (
    input  wire insn_t           insn,
    input  wire logic [XLEN-1:0] op_a,     // rs, or rd for immediate forms
    input  wire logic [XLEN-1:0] op_b,     // rt
    output logic      [XLEN-1:0] result
);

    logic [XLEN-1:0] lit_sext;
    logic [XLEN-1:0] lit_zext;

    assign lit_sext = {{(XLEN-LIT_W){insn.lit[LIT_W-1]}}, insn.lit};
    assign lit_zext = {{(XLEN-LIT_W){1'b0}}, insn.lit};

    always_comb begin
        result = '0;   // Branches, memory, halt and unknown
        case (insn.opcode)
            // ----------------------------------------------------------
            // Logic
            // ----------------------------------------------------------
            OP_AND:    result = op_a & op_b;
            OP_OR:     result = op_a | op_b;
            OP_XOR:    result = op_a ^ op_b;
            OP_NOT:    result = ~op_a;              // rt unused
            // Shifts, full 64-bit amount so 64 and up gives zero
            OP_SHFTR:  result = op_a >> op_b;
            OP_SHFTRI: result = op_a >> insn.lit;
            OP_SHFTL:  result = op_a << op_b;
            OP_SHFTLI: result = op_a << insn.lit;
            // ----------------------------------------------------------
            // Arithmetic
            // ----------------------------------------------------------
            OP_ADD:    result = op_a + op_b;
            OP_ADDI:   result = op_a + lit_sext;    // Signed literal
            OP_SUB:    result = op_a - op_b;
            OP_SUBI:   result = op_a - lit_zext;    // Unsigned literal
            OP_MUL:    result = op_a * op_b;        // Low 64 bits
            // Moves
            OP_MOV_RR: result = op_a;
            OP_MOV_RL: begin
                result             = op_a;          // Keep upper bits of rd
                result[LIT_W-1:0]  = insn.lit;
            end
            default:   result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/tinker_control.sv
// Multicycle control unit
`timescale 1ns/1ps
`default_nettype none

module tinker_control import tinker_pkg::*; #(
    parameter logic [ALEN-1:0] RESET_PC = 32'h2000
) (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  run,
    output logic      [ALEN-1:0]       fetch_addr,
    input  wire logic [ILEN-1:0]       fetch_insn,
    tinker_mem_if.ctrl                 mem,
    output logic      [REG_ADDR_W-1:0] rf_raddr_a,
    output logic      [REG_ADDR_W-1:0] rf_raddr_b,
    input  wire logic [XLEN-1:0]       rf_rdata_a,
    input  wire logic [XLEN-1:0]       rf_rdata_b,
    output logic                       wb_valid,
    output logic      [REG_ADDR_W-1:0] wb_reg,
    output logic      [XLEN-1:0]       wb_data,
    output logic                       halted
);

    state_t          state;
    logic [ALEN-1:0] pc;
    logic [ALEN-1:0] next_pc;
    insn_t           ir;        // Latched in FETCH
    logic [XLEN-1:0] result;    // ALU or load value
    logic [XLEN-1:0] alu_result;
    logic [ALEN-1:0] lit_sext;
    logic [ALEN-1:0] ea;        // Base plus offset

    tinker_alu u_alu (
        .insn   (ir),
        .op_a   (rf_rdata_a),
        .op_b   (rf_rdata_b),
        .result (alu_result)
    );

    // ----------------------------------------------------------
    // Operand selection
    // ----------------------------------------------------------
    always_comb begin
        rf_raddr_a = ir.rs;
        rf_raddr_b = ir.rt;
        case (ir.opcode)
            OP_ADDI, OP_SUBI, OP_SHFTRI, OP_SHFTLI, OP_MOV_RL: rf_raddr_a = ir.rd;
            OP_BRNZ: rf_raddr_b = ir.rd;       // Condition rs on A and target rd on B
            OP_ST: begin
                rf_raddr_a = ir.rd;            // Base
                rf_raddr_b = ir.rs;            // Data
            end
            default: ;
        endcase
    end

    assign lit_sext   = {{(ALEN-LIT_W){ir.lit[LIT_W-1]}}, ir.lit};
    assign ea         = rf_rdata_a[ALEN-1:0] + lit_sext;
    assign fetch_addr = pc;

    // Data port with the store strobe in MEMORY only
    assign mem.load_addr  = ea;
    assign mem.store_addr = ea;
    assign mem.store_data = rf_rdata_b;
    assign mem.store_we   = (state == MEMORY) && (ir.opcode == OP_ST);

    always_comb begin
        case (ir.opcode)
            OP_BRR_L: next_pc = pc + lit_sext;
            OP_BRNZ:  next_pc = (rf_rdata_a != '0) ? rf_rdata_b[ALEN-1:0] : pc + 4;
            default:  next_pc = pc + 4;
        endcase
    end

    // ----------------------------------------------------------
    // State and PC
    // ----------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= IDLE;
            pc    <= RESET_PC;
        end else begin
            case (state)
                IDLE:      if (run) state <= FETCH;   // Start on run level
                FETCH:     state <= DECODE;
                DECODE:    state <= EXECUTE;
                EXECUTE:   state <= (ir.opcode == OP_HALT) ? HALT : MEMORY;
                MEMORY: begin
                    state <= WRITEBACK;
                    pc    <= next_pc;
                end
                WRITEBACK: state <= FETCH;
                default:   state <= HALT;   // Stays until reset
            endcase
        end
    end

    // Instruction and result registers
    always_ff @(posedge clk) begin
        if (state == FETCH) ir <= insn_t'(fetch_insn);
        if (state == EXECUTE) result <= alu_result;
        if (state == MEMORY && ir.opcode == OP_LD) result <= mem.load_data;
    end

    // Write-back decode
    always_comb begin
        wb_valid = 1'b0;
        if (state == WRITEBACK) begin
            case (ir.opcode)
                OP_AND, OP_OR, OP_XOR, OP_NOT,
                OP_SHFTR, OP_SHFTRI, OP_SHFTL, OP_SHFTLI,
                OP_ADD, OP_ADDI, OP_SUB, OP_SUBI, OP_MUL,
                OP_MOV_RR, OP_MOV_RL, OP_LD: wb_valid = 1'b1;
                default: wb_valid = 1'b0;
            endcase
        end
    end

    assign wb_reg  = ir.rd;
    assign wb_data = result;
    assign halted  = (state == HALT);

    // A load from unwritten bytes would retire an unknown value
    a_wb_known: assert property (
        @(posedge clk) disable iff (reset)
        wb_valid |-> !$isunknown({wb_reg, wb_data})
    ) else $error("retire with unknown register or value");

endmodule

`default_nettype wire

//--- verilog/tinker_core.sv
// Tinker core top level
`timescale 1ns/1ps
`default_nettype none

module tinker_core import tinker_pkg::*; #(
    parameter int              MEM_BYTES = 16384,
    parameter logic [ALEN-1:0] RESET_PC  = 32'h2000
) (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  run,
    input  wire logic                  prog_we,
    input  wire logic [ALEN-1:0]       prog_addr,
    input  wire logic [ILEN-1:0]       prog_data,
    output logic                       wb_valid,
    output logic      [REG_ADDR_W-1:0] wb_reg,
    output logic      [XLEN-1:0]       wb_data,
    output logic                       halted
);

    logic [ALEN-1:0]       fetch_addr;
    logic [ILEN-1:0]       fetch_insn;
    logic [REG_ADDR_W-1:0] rf_raddr_a;
    logic [REG_ADDR_W-1:0] rf_raddr_b;
    logic [XLEN-1:0]       rf_rdata_a;
    logic [XLEN-1:0]       rf_rdata_b;

    tinker_mem_if mem_bus ();   // Control to memory data port

    tinker_mem #(.MEM_BYTES(MEM_BYTES)) u_mem (
        .clk, .mem(mem_bus.mem), .fetch_addr, .fetch_insn,
        .prog_we, .prog_addr, .prog_data
    );

    // Retire port doubles as the register write port
    tinker_regfile u_regfile (
        .clk, .reset, .we(wb_valid), .waddr(wb_reg), .wdata(wb_data),
        .raddr_a(rf_raddr_a), .raddr_b(rf_raddr_b),
        .rdata_a(rf_rdata_a), .rdata_b(rf_rdata_b)
    );

    tinker_control #(.RESET_PC(RESET_PC)) u_control (
        .clk, .reset, .run, .fetch_addr, .fetch_insn, .mem(mem_bus.ctrl),
        .rf_raddr_a, .rf_raddr_b, .rf_rdata_a, .rf_rdata_b,
        .wb_valid, .wb_reg, .wb_data, .halted
    );

    // Loader must not overwrite a running program
    a_prog_while_stopped: assert property (
        @(posedge clk) disable iff (reset) prog_we |-> !run
    ) else $error("program write while run is high");

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int HALF_PERIOD = 5   // 10 ns period
) (
    input  wire logic reset_req,    // Rising edge asks for a fresh reset
    output logic      clk,
    output logic      reset
);

    initial clk = 1'b0;
    always #HALF_PERIOD clk = ~clk;

    initial begin
        reset = 1'b1;               // Power-on reset
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;            // Released just after the edge
        forever begin
            @(posedge reset_req);
            reset = 1'b1;
            repeat (2) @(posedge clk);
            #1 reset = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- tests/tinker_tb.sv
// Tinker core testbench
`timescale 1ns/1ps
`default_nettype none

module tinker_tb;

    localparam logic [31:0] PROG_BASE     = 32'h2000;
    localparam int          NUM_TESTS     = 8;
    localparam int          MAX_WORDS     = 8;
    localparam int          SETTLE_CYCLES = 5;   // Watched after halt

    // ISA encodings
    localparam logic [4:0] OP_AND    = 5'h00;
    localparam logic [4:0] OP_OR     = 5'h01;
    localparam logic [4:0] OP_XOR    = 5'h02;
    localparam logic [4:0] OP_NOT    = 5'h03;
    localparam logic [4:0] OP_SHFTR  = 5'h04;
    localparam logic [4:0] OP_SHFTRI = 5'h05;
    localparam logic [4:0] OP_SHFTL  = 5'h06;
    localparam logic [4:0] OP_SHFTLI = 5'h07;
    localparam logic [4:0] OP_BRR    = 5'h0a;
    localparam logic [4:0] OP_BRNZ   = 5'h0b;
    localparam logic [4:0] OP_HALT   = 5'h0f;
    localparam logic [4:0] OP_LD     = 5'h10;
    localparam logic [4:0] OP_MOV_RR = 5'h11;
    localparam logic [4:0] OP_MOV_RL = 5'h12;
    localparam logic [4:0] OP_ST     = 5'h13;
    localparam logic [4:0] OP_ADD    = 5'h18;
    localparam logic [4:0] OP_ADDI   = 5'h19;
    localparam logic [4:0] OP_SUB    = 5'h1a;
    localparam logic [4:0] OP_SUBI   = 5'h1b;
    localparam logic [4:0] OP_MUL    = 5'h1c;

    logic        clk;
    logic        reset;
    logic        reset_req;
    logic        run;
    logic        prog_we;
    logic [31:0] prog_addr;
    logic [31:0] prog_data;
    logic        wb_valid;
    logic [4:0]  wb_reg;
    logic [63:0] wb_data;
    logic        halted;

    tb_clock clk_gen (.reset_req, .clk, .reset);

    tinker_core #(.MEM_BYTES(16384), .RESET_PC(PROG_BASE)) tinker_core_inst (
        .clk, .reset, .run, .prog_we, .prog_addr, .prog_data,
        .wb_valid, .wb_reg, .wb_data, .halted
    );

    // ----------------------------------------------------------
    // Test table
    // ----------------------------------------------------------
    string       test_name [NUM_TESTS];
    logic [31:0] prog      [NUM_TESTS][MAX_WORDS];
    int          n_words   [NUM_TESTS];
    logic [4:0]  exp_reg   [NUM_TESTS][MAX_WORDS];   // Retires in order
    logic [63:0] exp_val   [NUM_TESTS][MAX_WORDS];
    int          n_exp     [NUM_TESTS];

    logic [4:0]  got_reg [$];   // Collected from the retire port
    logic [63:0] got_val [$];
    string       cur_test = "startup";
    int          cycles = 0;
    int          timeout_limit = 100000;

    function automatic logic [31:0] encode(logic [4:0] op, int rd, int rs, int rt, int lit);
        return {op, 5'(rd), 5'(rs), 5'(rt), 12'(lit)};   // opcode rd rs rt L
    endfunction

    task automatic place_word(int t, logic [31:0] word);
        prog[t][n_words[t]] = word;
        n_words[t]++;
    endtask

    // Word that must retire r with value
    task automatic expect_retire(int t, logic [31:0] word, int r, logic [63:0] value);
        place_word(t, word);
        exp_reg[t][n_exp[t]] = 5'(r);
        exp_val[t][n_exp[t]] = value;
        n_exp[t]++;
    endtask

    task automatic build_tests;
        logic [11:0] a;
        logic [11:0] b;
        logic [11:0] s;
        logic [11:0] k;
        logic [11:0] k2;
        logic [11:0] v;
        logic [63:0] x;
        logic [63:0] y;
        int          total;
        test_name = '{"logic", "shift", "arith", "memory", "brr", "brnz", "halt", "reset"};
        a = 12'($urandom);
        b = 12'($urandom);
        expect_retire(0, encode(OP_MOV_RL, 1, 0, 0, a), 1, 64'(a));   // Seeds from zero
        expect_retire(0, encode(OP_MOV_RL, 2, 0, 0, b), 2, 64'(b));
        expect_retire(0, encode(OP_AND, 3, 1, 2, 0), 3, 64'(a & b));
        expect_retire(0, encode(OP_OR, 4, 1, 2, 0), 4, 64'(a | b));
        expect_retire(0, encode(OP_XOR, 5, 1, 2, 0), 5, 64'(a ^ b));
        expect_retire(0, encode(OP_NOT, 6, 1, 0, 0), 6, ~64'(a));
        place_word(0, encode(OP_HALT, 0, 0, 0, 0));
        // Shifts by register and literal amounts
        a  = 12'($urandom);
        s  = 12'($urandom % 64);
        k  = 12'($urandom % 12);
        k2 = 12'($urandom % 40);
        v  = 12'(64 + $urandom % 4000);   // 64 and up
        x  = 64'(a) << s;
        expect_retire(1, encode(OP_MOV_RL, 1, 0, 0, a), 1, 64'(a));
        expect_retire(1, encode(OP_MOV_RL, 2, 0, 0, s), 2, 64'(s));
        expect_retire(1, encode(OP_SHFTL, 3, 1, 2, 0), 3, x);
        expect_retire(1, encode(OP_SHFTRI, 3, 0, 0, k), 3, x >> k);
        expect_retire(1, encode(OP_SHFTLI, 1, 0, 0, k2), 1, 64'(a) << k2);
        expect_retire(1, encode(OP_MOV_RL, 5, 0, 0, v), 5, 64'(v));
        expect_retire(1, encode(OP_SHFTR, 6, 1, 5, 0), 6, 64'h0);   // Shifted out entirely
        place_word(1, encode(OP_HALT, 0, 0, 0, 0));
        // Arithmetic with a negative addi literal and a subi literal with bit 11 set
        a = 12'($urandom);
        b = 12'($urandom);
        k = 12'h800 | 12'($urandom);
        v = 12'h800 | 12'($urandom);
        x = 64'(a) + 64'(b);
        y = 64'(a) - 64'(b);
        expect_retire(2, encode(OP_MOV_RL, 1, 0, 0, a), 1, 64'(a));
        expect_retire(2, encode(OP_MOV_RL, 2, 0, 0, b), 2, 64'(b));
        expect_retire(2, encode(OP_ADD, 3, 1, 2, 0), 3, x);
        expect_retire(2, encode(OP_SUB, 4, 1, 2, 0), 4, y);
        expect_retire(2, encode(OP_MUL, 5, 3, 4, 0), 5, x * y);
        expect_retire(2, encode(OP_ADDI, 1, 0, 0, k), 1, 64'(a) + {{52{k[11]}}, k});
        expect_retire(2, encode(OP_SUBI, 2, 0, 0, v), 2, 64'(b) - {52'h0, v});
        place_word(2, encode(OP_HALT, 0, 0, 0, 0));
        // Two stores and an aligned reload followed by a load straddling both
        a = 12'($urandom) | 12'h001;
        k = 12'(20 + $urandom % 20);
        x = 64'(a) << k;
        expect_retire(3, encode(OP_MOV_RL, 1, 0, 0, 12'h100), 1, 64'h100);   // Base
        expect_retire(3, encode(OP_MOV_RL, 2, 0, 0, a), 2, 64'(a));
        expect_retire(3, encode(OP_SHFTLI, 2, 0, 0, k), 2, x);
        place_word(3, encode(OP_ST, 1, 2, 0, 0));
        place_word(3, encode(OP_ST, 1, 2, 0, 8));
        expect_retire(3, encode(OP_LD, 3, 1, 0, 8), 3, x);
        expect_retire(3, encode(OP_LD, 4, 1, 0, 4), 4, {x[31:0], x[63:32]});   // Big-endian
        place_word(3, encode(OP_HALT, 0, 0, 0, 0));
        // Relative branches over one and two words
        a = 12'($urandom);
        b = 12'($urandom);
        expect_retire(4, encode(OP_MOV_RL, 1, 0, 0, a), 1, 64'(a));
        place_word(4, encode(OP_BRR, 0, 0, 0, 8));
        place_word(4, encode(OP_MOV_RL, 2, 0, 0, b));   // Skipped
        expect_retire(4, encode(OP_MOV_RL, 3, 0, 0, b), 3, 64'(b));
        place_word(4, encode(OP_BRR, 0, 0, 0, 12));
        place_word(4, encode(OP_MOV_RL, 4, 0, 0, a));   // Skipped
        place_word(4, encode(OP_MOV_RL, 5, 0, 0, b));   // Skipped
        place_word(4, encode(OP_HALT, 0, 0, 0, 0));
        // brnz target in r1 is the halt word
        x = 64'(12'd2) << 12;
        y = {x[63:12], 12'h01c};
        v = 12'(1 + $urandom % 4095);   // Never zero
        expect_retire(5, encode(OP_MOV_RL, 1, 0, 0, 2), 1, 64'd2);
        expect_retire(5, encode(OP_SHFTLI, 1, 0, 0, 12), 1, x);
        expect_retire(5, encode(OP_MOV_RL, 1, 0, 0, 12'h01c), 1, y);
        place_word(5, encode(OP_BRNZ, 1, 0, 0, 0));   // r0 is zero so it falls through
        expect_retire(5, encode(OP_MOV_RL, 4, 0, 0, v), 4, 64'(v));
        place_word(5, encode(OP_BRNZ, 1, 4, 0, 0));   // Taken
        place_word(5, encode(OP_MOV_RL, 6, 0, 0, v));
        place_word(5, encode(OP_HALT, 0, 0, 0, 0));
        // Halt followed by registers cleared on the next reset
        expect_retire(6, encode(OP_MOV_RL, 7, 0, 0, a), 7, 64'(a));
        place_word(6, encode(OP_HALT, 0, 0, 0, 0));
        place_word(6, encode(OP_MOV_RL, 8, 0, 0, b));   // Never fetched
        expect_retire(7, encode(OP_MOV_RR, 9, 7, 0, 0), 9, 64'h0);
        place_word(7, encode(OP_HALT, 0, 0, 0, 0));
        total = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            total += n_words[t];
        end
        timeout_limit = 5 * total * 2 + 100;
    endtask

    // ----------------------------------------------------------
    // Checking and sequencing
    // ----------------------------------------------------------
    task automatic check_value(string what, logic [63:0] expected, logic [63:0] actual);
        if (expected !== actual) begin
            $display("ERR %s %s: expected %h, actual %h", cur_test, what, expected, actual);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    // Retires sampled mid-cycle
    always @(negedge clk) begin
        if (wb_valid) begin
            got_reg.push_back(wb_reg);
            got_val.push_back(wb_data);
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > timeout_limit) begin
            $display("Run timed out after %0d cycles in test %s", cycles, cur_test);
            $display("Finished with errors");
            $fatal(1);
        end
    end

    task automatic reset_core;
        reset_req = 1'b1;
        @(negedge reset);   // Falls 1 ns after an edge
        reset_req = 1'b0;
    endtask

    task automatic load_program(int t);
        for (int i = 0; i < n_words[t]; i++) begin
            prog_we   = 1'b1;
            prog_addr = PROG_BASE + 32'(4 * i);
            prog_data = prog[t][i];
            @(posedge clk);
            #1;
        end
        prog_we = 1'b0;
    endtask

    task automatic run_test(int t);
        cur_test = test_name[t];
        reset_core();
        load_program(t);
        got_reg.delete();
        got_val.delete();
        run = 1'b1;
        while (!halted) @(negedge clk);
        repeat (SETTLE_CYCLES) begin   // halted must stay high
            @(negedge clk);
            check_value("halted level", 64'd1, 64'(halted));
        end
        @(posedge clk);
        #1 run = 1'b0;
        check_value("retire count", 64'(n_exp[t]), 64'(got_reg.size()));
        for (int i = 0; i < n_exp[t]; i++) begin
            check_value($sformatf("retire %0d register", i), 64'(exp_reg[t][i]), 64'(got_reg[i]));
            check_value($sformatf("retire %0d value", i), exp_val[t][i], got_val[i]);
        end
    endtask

    initial begin
        void'($urandom(40));
        reset_req = 1'b0;
        run       = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        build_tests();
        @(negedge reset);
        @(posedge clk);
        #1;
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
verilog/tinker_pkg.sv
verilog/tinker_mem_if.sv
verilog/tinker_mem.sv
verilog/tinker_regfile.sv
verilog/tinker_alu.sv
verilog/tinker_control.sv
verilog/tinker_core.sv
tests/tb_clock.sv
tests/tinker_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the tinker core testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal --top-module tinker_tb \
        -f flist.f --Mdir obj_dir -o tinker_sim > "$BUILD_LOG" 2>&1; then
    cat "$BUILD_LOG"
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/tinker_sim > "$SIM_LOG" 2>&1; then
    cat "$SIM_LOG"
    echo "Simulation exited with an error"
    exit 1
fi

cat "$SIM_LOG"
if grep -qx "Finished with no errors" "$SIM_LOG"; then
    exit 0
else
    exit 1
fi
